// File: mmio_consts.svh
`ifndef MMIO_CONSTS_SVH
`define MMIO_CONSTS_SVH

// region bounds, byte addresses
`define MMIO_INSTR_HI    32'd1024        // last instruction address, inclusive
`define MMIO_DATA_LO     32'd1056        // data starts above this
`define MMIO_DATA_HI     32'd1792        // last data address, display starts above
`define MMIO_DISP_HI     32'd2048        // display ends below this

// bank geometry
`define MMIO_NUM_BANKS   4               // bank index is addr[3:2]
`define MMIO_BANK_WORDS  128             // row is addr[10:4]

// queues and display timing
`define MMIO_ROUTE_DEPTH 8               // also the max requests in flight
`define MMIO_DISP_DEPTH  4               // pending display commands
`define MMIO_DISP_CYCLES 6               // strobe to response

`define MMIO_ERR_DATA    32'hDEADBEEF    // rdata of an error response

`endif

// File: mmio_pkg.sv
package mmio_pkg;

    // cpu operation, same encoding as the rwi bits
    typedef enum logic [1:0] {
        OP_IDLE  = 2'b00,
        OP_WRITE = 2'b01,
        OP_READ  = 2'b10,
        OP_FETCH = 2'b11
    } mmio_op_e;

    typedef struct packed {
        mmio_op_e    op;
        logic [31:0] addr;   // byte address, low two bits ignored
        logic [31:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        err;    // set only by the error path
    } mem_rsp_t;

    // where the response of a request will come from
    typedef enum logic [1:0] {
        ROUTE_BANK = 2'd0,
        ROUTE_DISP = 2'd1,
        ROUTE_ERR  = 2'd2
    } route_kind_e;

    typedef struct packed {
        route_kind_e kind;
        logic [1:0]  bank;   // only meaningful for ROUTE_BANK
    } route_t;

endpackage

// File: sync_fifo.sv
`timescale 1ns/1ns

module sync_fifo #(
    parameter type T     = logic,
    parameter int  DEPTH = 4
) (
    input  logic clk,
    input  logic arst_n_i,
    input  logic in_valid_i,
    output logic in_ready_o,
    input  T     in_data_i,
    output logic out_valid_o,
    input  logic out_ready_i,
    output T     out_data_o,
    output logic empty_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    T                 mem [DEPTH];   // payload store
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;         // one extra bit so full is representable
    logic             push;
    logic             pop;

    assign empty_o     = (count == '0);
    assign out_valid_o = !empty_o;
    assign out_data_o  = mem[rd_ptr];
    assign in_ready_o  = (count != (PTR_W+1)'(DEPTH)) || out_ready_i; // full but draining
    assign push        = in_valid_i && in_ready_o;
    assign pop         = out_valid_o && out_ready_i;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1; // wrap
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data_i;
        end
    end

endmodule

// File: mmio_decoder.sv
`timescale 1ns/1ns
`include "mmio_consts.svh"

module mmio_decoder (
    // cpu side
    input  logic                        req_valid_i,
    output logic                        req_ready_o,
    input  mmio_pkg::mem_req_t          req_i,
    // banks, one request broadcast, valid per bank
    output logic [`MMIO_NUM_BANKS-1:0]  bank_valid_o,
    input  logic [`MMIO_NUM_BANKS-1:0]  bank_ready_i,
    output mmio_pkg::mem_req_t          bank_req_o,
    // display port
    output logic                        disp_valid_o,
    input  logic                        disp_ready_i,
    output mmio_pkg::mem_req_t          disp_req_o,
    // route queue in the merger
    output logic                        route_valid_o,
    input  logic                        route_ready_i,
    output mmio_pkg::route_t            route_o
);
    import mmio_pkg::*;

    logic        in_instr;      // 0 .. 1024
    logic        in_data;       // 1057 .. 1792
    logic        in_disp;       // 1793 .. 2047
    logic        is_rw;
    logic        is_fetch;
    logic [1:0]  bank_sel;
    route_kind_e kind;
    logic        target_ready;  // readiness of whichever target was chosen

    assign in_instr = (req_i.addr <= `MMIO_INSTR_HI);
    assign in_data  = (req_i.addr > `MMIO_DATA_LO) && (req_i.addr <= `MMIO_DATA_HI);
    assign in_disp  = (req_i.addr > `MMIO_DATA_HI) && (req_i.addr < `MMIO_DISP_HI);
    assign is_rw    = (req_i.op == OP_READ) || (req_i.op == OP_WRITE);
    assign is_fetch = (req_i.op == OP_FETCH);
    assign bank_sel = req_i.addr[3:2];   // word interleave

    always_comb begin
        kind = ROUTE_ERR;   // idle and out of region land here
        if ((in_instr && (is_fetch || is_rw)) || (in_data && is_rw)) begin
            kind = ROUTE_BANK;
        end else if (in_disp && is_rw) begin
            kind = ROUTE_DISP;   // no fetch from the screen
        end
    end

    always_comb begin
        case (kind)
            ROUTE_BANK: target_ready = bank_ready_i[bank_sel];
            ROUTE_DISP: target_ready = disp_ready_i;
            default:    target_ready = 1'b1;   // error needs only the route slot
        endcase
    end

    // request and route entry move in the same cycle or not at all
    assign req_ready_o   = route_ready_i && target_ready;
    assign route_valid_o = req_valid_i && target_ready;
    assign route_o       = '{kind: kind, bank: bank_sel};

    always_comb begin
        bank_valid_o           = '0;
        bank_valid_o[bank_sel] = req_valid_i && route_ready_i && (kind == ROUTE_BANK);
    end
    assign disp_valid_o = req_valid_i && route_ready_i && (kind == ROUTE_DISP);

    assign bank_req_o = req_i;   // broadcast, only the selected bank sees valid

    always_comb begin
        disp_req_o      = req_i;
        disp_req_o.addr = req_i.addr - `MMIO_DATA_HI;   // screen offset 1 .. 255
    end

endmodule

// File: mem_bank.sv
`timescale 1ns/1ns
`include "mmio_consts.svh"

module mem_bank (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               req_valid_i,
    output logic               req_ready_o,
    input  mmio_pkg::mem_req_t req_i,
    output logic               rsp_valid_o,
    input  logic               rsp_ready_i,
    output mmio_pkg::mem_rsp_t rsp_o
);
    import mmio_pkg::*;

    localparam int ROW_W = $clog2(`MMIO_BANK_WORDS);

    logic [31:0]      mem [`MMIO_BANK_WORDS];
    logic [ROW_W-1:0] row;
    logic             accept;
    logic             is_write;

    assign row      = req_i.addr[ROW_W+3:4];   // above the bank index bits
    assign is_write = (req_i.op == OP_WRITE);

    // slot empty, or emptied this cycle
    assign req_ready_o = !rsp_valid_o || rsp_ready_i;
    assign accept      = req_valid_i && req_ready_o;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rsp_valid_o <= 1'b0;
        end else if (accept) begin
            rsp_valid_o <= 1'b1;   // answer next cycle
        end else if (rsp_ready_i) begin
            rsp_valid_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept && is_write) begin
            mem[row] <= req_i.wdata;
        end
        if (accept) begin
            rsp_o.rdata <= is_write ? 32'd0 : mem[row];   // writes answer zero
            rsp_o.err   <= 1'b0;
        end
    end

endmodule

// File: display_port.sv
`timescale 1ns/1ns
`include "mmio_consts.svh"

module display_port (
    input  logic               clk,
    input  logic               arst_n_i,
    input  logic               req_valid_i,
    output logic               req_ready_o,
    input  mmio_pkg::mem_req_t req_i,
    output logic               rsp_valid_o,
    input  logic               rsp_ready_i,
    output mmio_pkg::mem_rsp_t rsp_o,
    // spi tft side
    output logic               disp_write_o,
    output logic               disp_read_o,
    output logic [7:0]         disp_addr_o,
    output logic [31:0]        disp_data_o,
    input  logic [31:0]        disp_rdata_i
);
    import mmio_pkg::*;

    localparam int CNT_W = $clog2(`MMIO_DISP_CYCLES);

    typedef enum logic [1:0] {ST_IDLE, ST_BUSY, ST_RSP} state_e;

    state_e           state;
    logic [CNT_W-1:0] cnt;         // cycles left of the access
    logic             cur_wr;      // command in flight is a write
    logic             cmd_valid;
    logic             cmd_pop;
    logic             done;
    mem_req_t         cmd;

    sync_fifo #(
        .T     (mem_req_t),
        .DEPTH (`MMIO_DISP_DEPTH)
    ) u_cmd_fifo (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .in_valid_i  (req_valid_i),
        .in_ready_o  (req_ready_o),
        .in_data_i   (req_i),
        .out_valid_o (cmd_valid),
        .out_ready_i (cmd_pop),
        .out_data_o  (cmd),
        .empty_o     ()
    );

    assign cmd_pop     = cmd_valid && (state == ST_IDLE);   // one command at a time
    assign done        = (state == ST_BUSY) && (cnt == '0);
    assign rsp_valid_o = (state == ST_RSP);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state        <= ST_IDLE;
            cnt          <= '0;
            cur_wr       <= 1'b0;
            disp_write_o <= 1'b0;
            disp_read_o  <= 1'b0;
        end else begin
            disp_write_o <= 1'b0;   // strobes last one cycle
            disp_read_o  <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (cmd_valid) begin
                        disp_write_o <= (cmd.op == OP_WRITE);
                        disp_read_o  <= (cmd.op == OP_READ);
                        cur_wr       <= (cmd.op == OP_WRITE);
                        cnt          <= CNT_W'(`MMIO_DISP_CYCLES - 1);
                        state        <= ST_BUSY;
                    end
                end
                ST_BUSY: begin
                    if (cnt == '0) begin
                        state <= ST_RSP;   // valid DISP_CYCLES after the strobe
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                ST_RSP: begin
                    if (rsp_ready_i) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_pop) begin
            disp_addr_o <= cmd.addr[7:0];   // held past the strobe
            disp_data_o <= cmd.wdata;
        end
        if (done) begin
            rsp_o.rdata <= cur_wr ? 32'd0 : disp_rdata_i;   // screen data at completion
            rsp_o.err   <= 1'b0;
        end
    end

endmodule

// File: rsp_merge.sv
`timescale 1ns/1ns
`include "mmio_consts.svh"

module rsp_merge #(
    parameter int NUM_BANKS = `MMIO_NUM_BANKS
) (
    input  logic                   clk,
    input  logic                   arst_n_i,
    // route entries from the decoder
    input  logic                   route_valid_i,
    output logic                   route_ready_o,
    input  mmio_pkg::route_t       route_i,
    // bank responses
    input  logic [NUM_BANKS-1:0]   bank_rsp_valid_i,
    output logic [NUM_BANKS-1:0]   bank_rsp_ready_o,
    input  mmio_pkg::mem_rsp_t     bank_rsp_i [NUM_BANKS],
    // display response
    input  logic                   disp_rsp_valid_i,
    output logic                   disp_rsp_ready_o,
    input  mmio_pkg::mem_rsp_t     disp_rsp_i,
    // to cpu
    output logic                   rsp_valid_o,
    input  logic                   rsp_ready_i,
    output mmio_pkg::mem_rsp_t     rsp_o,
    output logic                   busy_o
);
    import mmio_pkg::*;

    logic   head_valid;
    logic   head_pop;
    logic   route_empty;
    route_t head;   // oldest outstanding request

    sync_fifo #(
        .T     (route_t),
        .DEPTH (`MMIO_ROUTE_DEPTH)
    ) u_route_fifo (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .in_valid_i  (route_valid_i),
        .in_ready_o  (route_ready_o),
        .in_data_i   (route_i),
        .out_valid_o (head_valid),
        .out_ready_i (head_pop),
        .out_data_o  (head),
        .empty_o     (route_empty)
    );

    always_comb begin
        rsp_valid_o      = 1'b0;
        rsp_o            = '0;
        bank_rsp_ready_o = '0;
        disp_rsp_ready_o = 1'b0;
        if (head_valid) begin
            case (head.kind)
                ROUTE_BANK: begin
                    rsp_valid_o                 = bank_rsp_valid_i[head.bank];
                    rsp_o                       = bank_rsp_i[head.bank];
                    bank_rsp_ready_o[head.bank] = rsp_ready_i;   // pass handshake through
                end
                ROUTE_DISP: begin
                    rsp_valid_o      = disp_rsp_valid_i;
                    rsp_o            = disp_rsp_i;
                    disp_rsp_ready_o = rsp_ready_i;
                end
                default: begin
                    rsp_valid_o = 1'b1;   // error answered locally
                    rsp_o       = '{rdata: `MMIO_ERR_DATA, err: 1'b1};
                end
            endcase
        end
    end

    assign head_pop = rsp_valid_o && rsp_ready_i;   // retire on cpu handshake
    assign busy_o   = !route_empty;

endmodule

// File: mmio_top.sv
`timescale 1ns/1ns
`include "mmio_consts.svh"

module mmio_top (
    input  logic               clk,
    input  logic               arst_n_i,
    // cpu request / response
    input  logic               req_valid_i,
    output logic               req_ready_o,
    input  mmio_pkg::mem_req_t req_i,
    output logic               rsp_valid_o,
    input  logic               rsp_ready_i,
    output mmio_pkg::mem_rsp_t rsp_o,
    output logic               busy_o,
    // spi tft
    output logic               disp_write_o,
    output logic               disp_read_o,
    output logic [7:0]         disp_addr_o,
    output logic [31:0]        disp_data_o,
    input  logic [31:0]        disp_rdata_i
);
    import mmio_pkg::*;

    logic [`MMIO_NUM_BANKS-1:0] bank_valid;
    logic [`MMIO_NUM_BANKS-1:0] bank_ready;
    mem_req_t                   bank_req;       // shared by every bank
    logic [`MMIO_NUM_BANKS-1:0] bank_rsp_valid;
    logic [`MMIO_NUM_BANKS-1:0] bank_rsp_ready;
    mem_rsp_t                   bank_rsp [`MMIO_NUM_BANKS];
    logic                       disp_valid;
    logic                       disp_ready;
    mem_req_t                   disp_req;
    logic                       disp_rsp_valid;
    logic                       disp_rsp_ready;
    mem_rsp_t                   disp_rsp;
    logic                       route_valid;
    logic                       route_ready;
    route_t                     route;

    mmio_decoder u_decoder (
        .req_valid_i   (req_valid_i),
        .req_ready_o   (req_ready_o),
        .req_i         (req_i),
        .bank_valid_o  (bank_valid),
        .bank_ready_i  (bank_ready),
        .bank_req_o    (bank_req),
        .disp_valid_o  (disp_valid),
        .disp_ready_i  (disp_ready),
        .disp_req_o    (disp_req),
        .route_valid_o (route_valid),
        .route_ready_i (route_ready),
        .route_o       (route)
    );

    for (genvar i = 0; i < `MMIO_NUM_BANKS; i++) begin : g_bank
        mem_bank u_bank (
            .clk         (clk),
            .arst_n_i    (arst_n_i),
            .req_valid_i (bank_valid[i]),
            .req_ready_o (bank_ready[i]),
            .req_i       (bank_req),
            .rsp_valid_o (bank_rsp_valid[i]),
            .rsp_ready_i (bank_rsp_ready[i]),
            .rsp_o       (bank_rsp[i])
        );
    end

    display_port u_display (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .req_valid_i  (disp_valid),
        .req_ready_o  (disp_ready),
        .req_i        (disp_req),
        .rsp_valid_o  (disp_rsp_valid),
        .rsp_ready_i  (disp_rsp_ready),
        .rsp_o        (disp_rsp),
        .disp_write_o (disp_write_o),
        .disp_read_o  (disp_read_o),
        .disp_addr_o  (disp_addr_o),
        .disp_data_o  (disp_data_o),
        .disp_rdata_i (disp_rdata_i)
    );

    rsp_merge #(
        .NUM_BANKS (`MMIO_NUM_BANKS)
    ) u_merge (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .route_valid_i    (route_valid),
        .route_ready_o    (route_ready),
        .route_i          (route),
        .bank_rsp_valid_i (bank_rsp_valid),
        .bank_rsp_ready_o (bank_rsp_ready),
        .bank_rsp_i       (bank_rsp),
        .disp_rsp_valid_i (disp_rsp_valid),
        .disp_rsp_ready_o (disp_rsp_ready),
        .disp_rsp_i       (disp_rsp),
        .rsp_valid_o      (rsp_valid_o),
        .rsp_ready_i      (rsp_ready_i),
        .rsp_o            (rsp_o),
        .busy_o           (busy_o)
    );

endmodule

// File: tb_mmio_top.sv
`timescale 1ns/1ns
`include "mmio_consts.svh"

module tb_mmio_top;
    import mmio_pkg::*;

    localparam logic [31:0] LFSR_SEED = 32'hafc6;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;   // x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] DATA_BASE = 32'd1060;       // first word above the gap
    localparam int N_MEM   = 16;                         // words in the data region set
    localparam int N_RAND  = 40;
    localparam int N_REQS  = 2 * N_MEM + 12 + 9 + 7 + N_RAND;
    localparam int TIMEOUT_CYCLES = 30 * N_REQS + 40;   // reset and idle gaps on top
    localparam int T_BANK = 0;
    localparam int T_DISP = 1;
    localparam int T_ERR  = 2;

    logic        clk;
    logic        arst_n_i;
    logic        req_valid_i;
    logic        req_ready_o;
    mem_req_t    req_i;
    logic        rsp_valid_o;
    logic        rsp_ready_i;
    mem_rsp_t    rsp_o;
    logic        busy_o;
    logic        disp_write_o;
    logic        disp_read_o;
    logic [7:0]  disp_addr_o;
    logic [31:0] disp_data_o;
    logic [31:0] disp_rdata_i;

    logic [31:0] lfsr;
    logic [31:0] shadow [512];      // word image, indexed by addr[10:2]
    mem_req_t    stim_q [$];
    mem_rsp_t    exp_q [$];         // responses in request order
    logic [39:0] disp_wr_q [$];     // {offset, data} per display write
    logic [39:0] disp_rd_q [$];     // {offset, screen word} per display read
    logic [31:0] rdata_next = '0;
    logic [39:0] disp_exp;
    mem_rsp_t    exp_rsp;
    mem_rsp_t    held_rsp;
    logic        was_waiting = 1'b0;
    int          checks = 0;
    int          errors = 0;
    int          acc_count = 0;
    int          rsp_count = 0;
    int          cycles = 0;
    int          test_num = 0;
    int          test_err_base = 0;

    mmio_top uut (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .req_valid_i  (req_valid_i),
        .req_ready_o  (req_ready_o),
        .req_i        (req_i),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_ready_i  (rsp_ready_i),
        .rsp_o        (rsp_o),
        .busy_o       (busy_o),
        .disp_write_o (disp_write_o),
        .disp_read_o  (disp_read_o),
        .disp_addr_o  (disp_addr_o),
        .disp_data_o  (disp_data_o),
        .disp_rdata_i (disp_rdata_i)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;   // 40 ns period
    end

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check_value(input string sig, input logic [31:0] exp, input logic [31:0] got);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] %0t %s expected %h got %h", $time, sig, exp, got);
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("%0t: %s", $time, what);
        end
    endtask

    // region rules of the memory map
    function automatic int target_of(input mem_req_t r);
        if (r.op == OP_IDLE) return T_ERR;
        if (r.addr <= `MMIO_INSTR_HI) return T_BANK;   // write, read and fetch
        if (r.addr > `MMIO_DATA_LO && r.addr <= `MMIO_DATA_HI) begin
            return (r.op == OP_FETCH) ? T_ERR : T_BANK;
        end
        if (r.addr > `MMIO_DATA_HI && r.addr < `MMIO_DISP_HI) begin
            return (r.op == OP_FETCH) ? T_ERR : T_DISP;
        end
        return T_ERR;
    endfunction

    task automatic record_accept(input mem_req_t r);
        logic [31:0] v;
        logic [7:0]  offs;
        offs = 8'(r.addr - `MMIO_DATA_HI);
        case (target_of(r))
            T_BANK: begin
                if (r.op == OP_WRITE) begin
                    shadow[r.addr[10:2]] = r.wdata;
                    exp_q.push_back('{rdata: 32'd0, err: 1'b0});   // write ack
                end else begin
                    exp_q.push_back('{rdata: shadow[r.addr[10:2]], err: 1'b0});
                end
            end
            T_DISP: begin
                if (r.op == OP_WRITE) begin
                    disp_wr_q.push_back({offs, r.wdata});
                    exp_q.push_back('{rdata: 32'd0, err: 1'b0});
                end else begin
                    v = rand_bits(32);   // word the screen will return
                    disp_rd_q.push_back({offs, v});
                    exp_q.push_back('{rdata: v, err: 1'b0});
                end
            end
            default: exp_q.push_back('{rdata: `MMIO_ERR_DATA, err: 1'b1});
        endcase
    endtask

    task automatic queue_req(input mmio_op_e op, input logic [31:0] addr,
                             input logic [31:0] wdata);
        stim_q.push_back('{op: op, addr: addr, wdata: wdata});
    endtask

    // sends stim_q and waits until the DUT has answered every accepted request
    task automatic run_traffic(input bit random_mode);
        bit sent;
        sent = 1'b0;
        while (stim_q.size() > 0 || req_valid_i || busy_o) begin
            @(posedge clk);
            #2;
            if (sent) begin
                req_valid_i = 1'b0;
                sent        = 1'b0;
            end
            rsp_ready_i = !random_mode || (rand_bits(2) != 0);   // 3 of 4 when random
            if (!req_valid_i && stim_q.size() > 0) begin
                if (!random_mode || rand_bits(1) == 1) begin   // random gaps
                    req_i       = stim_q.pop_front();
                    req_valid_i = 1'b1;
                end
            end
            @(negedge clk);
            if (req_valid_i && req_ready_o) begin
                record_accept(req_i);
                acc_count++;
                sent = 1'b1;
            end
        end
    endtask

    task automatic finish_test(input string name);
        @(posedge clk);
        #2;
        rsp_ready_i = 1'b0;
        @(negedge clk);
        check_true(!busy_o && !rsp_valid_o, "DUT not idle after the last response");
        check_true(exp_q.size() == 0, "responses still outstanding at end of test");
        check_true(disp_wr_q.size() == 0 && disp_rd_q.size() == 0,
                   "display access never reached the screen interface");
        check_true(rsp_count == acc_count, "response count differs from accepted requests");
        test_num++;
        $display("test %0d %-12s %0d errors, %0d requests so far",
                 test_num, name, errors - test_err_base, acc_count);
        test_err_base = errors;
    endtask

    // screen side, answers a read strobe with the recorded word
    initial begin
        disp_rdata_i = '0;
        forever begin
            @(posedge clk);
            #2;
            disp_rdata_i = rdata_next;
        end
    end

    always @(negedge clk) begin
        if (arst_n_i) begin
            if (disp_write_o) begin
                check_true(!disp_read_o, "both display strobes high in one cycle");
                check_true(disp_wr_q.size() > 0, "display write strobe with no write pending");
                if (disp_wr_q.size() > 0) begin
                    disp_exp = disp_wr_q.pop_front();
                    check_value("disp_addr_o", 32'(disp_exp[39:32]), 32'(disp_addr_o));
                    check_value("disp_data_o", disp_exp[31:0], disp_data_o);
                end
            end
            if (disp_read_o) begin
                check_true(disp_rd_q.size() > 0, "display read strobe with no read pending");
                if (disp_rd_q.size() > 0) begin
                    disp_exp = disp_rd_q.pop_front();
                    check_value("disp_addr_o", 32'(disp_exp[39:32]), 32'(disp_addr_o));
                    rdata_next = disp_exp[31:0];
                end
            end
        end
    end

    // response order, data and hold under back-pressure
    always @(negedge clk) begin
        if (arst_n_i) begin
            if (was_waiting) begin
                check_true(rsp_valid_o, "rsp_valid_o dropped before the response was taken");
                check_value("rsp_o.rdata", held_rsp.rdata, rsp_o.rdata);
                check_value("rsp_o.err", 32'(held_rsp.err), 32'(rsp_o.err));
            end
            if (rsp_valid_o && rsp_ready_i) begin
                rsp_count++;
                check_true(exp_q.size() > 0, "response with no request outstanding");
                if (exp_q.size() > 0) begin
                    exp_rsp = exp_q.pop_front();
                    check_value("rsp_o.rdata", exp_rsp.rdata, rsp_o.rdata);
                    check_value("rsp_o.err", 32'(exp_rsp.err), 32'(rsp_o.err));
                end
            end
            was_waiting = rsp_valid_o && !rsp_ready_i;
            held_rsp    = rsp_o;
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, %0d of %0d responses seen",
                     cycles, rsp_count, acc_count);
            $display("Verification failed");
            $finish;
        end
    end

    initial begin
        arst_n_i    = 1'b0;
        req_valid_i = 1'b0;
        req_i       = '0;
        rsp_ready_i = 1'b0;
        lfsr        = LFSR_SEED;
        repeat (2) @(posedge clk);
        #2;
        arst_n_i = 1'b1;

        @(negedge clk);
        check_value("rsp_valid_o", 32'd0, 32'(rsp_valid_o));
        check_value("busy_o", 32'd0, 32'(busy_o));
        check_value("disp_write_o", 32'd0, 32'(disp_write_o));
        check_value("disp_read_o", 32'd0, 32'(disp_read_o));
        finish_test("reset");

        for (int i = 0; i < N_MEM; i++) begin
            queue_req(OP_WRITE, DATA_BASE + 4 * i, rand_bits(32));   // all four banks
        end
        for (int i = 0; i < N_MEM; i++) begin
            queue_req(OP_READ, DATA_BASE + 4 * i, 32'd0);
        end
        run_traffic(1'b0);
        finish_test("memory");

        for (int i = 0; i < 4; i++) begin
            queue_req(OP_WRITE, 4 * i, rand_bits(32));   // program load by writes
        end
        queue_req(OP_WRITE, `MMIO_INSTR_HI, rand_bits(32));
        for (int i = 0; i < 4; i++) begin
            queue_req(OP_FETCH, 4 * i, 32'd0);
        end
        queue_req(OP_FETCH, `MMIO_INSTR_HI, 32'd0);
        queue_req(OP_FETCH, DATA_BASE, 32'd0);     // fetch from data is illegal
        queue_req(OP_READ, `MMIO_INSTR_HI, 32'd0);
        run_traffic(1'b0);
        finish_test("fetch");

        queue_req(OP_IDLE, DATA_BASE, 32'd0);
        queue_req(OP_READ, 32'd1028, 32'd0);       // gap between regions
        queue_req(OP_WRITE, `MMIO_DATA_LO, 32'h1234_5678);
        queue_req(OP_READ, DATA_BASE, 32'd0);      // legal one in between
        queue_req(OP_READ, `MMIO_DISP_HI, 32'd0);
        queue_req(OP_FETCH, `MMIO_DATA_HI, 32'd0);
        queue_req(OP_READ, 32'h0001_0000, 32'd0);
        queue_req(OP_IDLE, 32'd0, 32'd0);
        queue_req(OP_READ, DATA_BASE + 4, 32'd0);
        run_traffic(1'b0);
        finish_test("errors");

        queue_req(OP_WRITE, `MMIO_DATA_HI + 4, rand_bits(32));
        queue_req(OP_WRITE, 32'd2044, rand_bits(32));   // last display word
        queue_req(OP_READ, `MMIO_DATA_HI + 8, 32'd0);
        queue_req(OP_READ, DATA_BASE + 8, 32'd0);       // bank behind slow display
        queue_req(OP_WRITE, `MMIO_DATA_HI + 12, rand_bits(32));
        queue_req(OP_READ, 32'd2040, 32'd0);
        queue_req(OP_READ, DATA_BASE + 12, 32'd0);
        run_traffic(1'b0);
        finish_test("display");

        for (int i = 0; i < N_RAND; i++) begin
            case (rand_bits(3))
                0, 1, 2, 3: queue_req(OP_READ, DATA_BASE + 4 * rand_bits(4), 32'd0);
                4: queue_req(OP_WRITE, DATA_BASE + 4 * rand_bits(4), rand_bits(32));
                5: queue_req(rand_bits(1) ? OP_READ : OP_WRITE,
                             `MMIO_DATA_HI + 4 * (1 + rand_bits(5)), rand_bits(32));
                6: queue_req(OP_READ, `MMIO_DISP_HI + 4 * rand_bits(8), 32'd0);
                default: queue_req(OP_FETCH, 4 * rand_bits(2), 32'd0);
            endcase
        end
        run_traffic(1'b1);
        finish_test("backpressure");

        $display("checks %0d, errors %0d, requests %0d, responses %0d",
                 checks, errors, acc_count, rsp_count);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+.
mmio_pkg.sv
sync_fifo.sv
mmio_decoder.sv
mem_bank.sv
display_port.sv
rsp_merge.sv
mmio_top.sv
tb_mmio_top.sv

// File: Makefile
SIM      = verilator
TOP      = tb_mmio_top
FILELIST = filelist.f
VFLAGS   = --binary --timing --assert -Wno-fatal --timescale 1ns/1ns -j 0
OBJ_DIR  = obj_dir
SIM_BIN  = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
FAIL_MSG = Verification failed
PASS_MSG = Verification passed

SOURCES  = $(filter %.sv %.v,$(shell cat $(FILELIST))) $(wildcard *.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@! grep -q "$(FAIL_MSG)" $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
